// ==== build.f ====
verilog/stream_pkg.sv
verilog/csr_pkg.sv
verilog/pipeline_fifo.sv
verilog/pkt_monitor.sv
verilog/link_csr.sv
verilog/stream_link_top.sv
test/tb_stream_link.sv

// ==== test/tb_stream_link.sv ====
// --------------------------------------
// Stream link testbench
// Directed packet, flow control and CSR tests
// --------------------------------------
module tb_stream_link;

    import stream_pkg::*;
    import csr_pkg::*;

    localparam int TIMEOUT = 1000;

    logic     clk = 1'b0;
    logic     rst;
    beat_t    s_beat;
    logic     s_valid;
    logic     s_ready;
    beat_t    m_beat;
    logic     m_valid;
    logic     m_ready;
    desc_t    m_desc;
    logic     m_desc_valid;
    logic     m_desc_ready;
    csr_req_t csr_req;
    csr_rsp_t csr_rsp;

    integer   seed = 32'hba61;
    logic     stall_en;
    beat_t    pkt_q[$];
    beat_t    exp_q[$];
    int       max_beats_cfg;
    int       pkts_sent;
    int       oversize_sent;

    stream_link_top #(
        .DATA_LENGTH (4),
        .DESC_LENGTH (2)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .m_beat       (m_beat),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .m_desc       (m_desc),
        .m_desc_valid (m_desc_valid),
        .m_desc_ready (m_desc_ready),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp)
    );

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic csr_write(input logic [1:0] addr, input logic [15:0] data);
        @(negedge clk);
        csr_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge clk);
        csr_req.wr = 1'b0;
    endtask

    // Response is due exactly one cycle after the request
    task automatic csr_read(input logic [1:0] addr, output logic [15:0] data);
        @(negedge clk);
        csr_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 16'h0};
        @(negedge clk);
        csr_req.rd = 1'b0;
        check("csr_rsp.valid", csr_rsp.valid, 1'b1);
        data = csr_rsp.rdata;
    endtask

    task automatic build_packet(input int n, input int id);
        beat_t b;
        pkt_q.delete();
        for (int i = 0; i < n; i++) begin
            b.data = {id[7:0], 8'h5a, i[15:0]};
            b.keep = '1;
            b.last = (i == n - 1);
            b.user = 1'b0;
            pkt_q.push_back(b);
        end
    endtask

    task automatic mark_beat(input int idx, input logic [3:0] keep, input logic user);
        beat_t b;
        b = pkt_q[idx];
        b.keep = keep;
        b.user = user;
        pkt_q[idx] = b;
    endtask

    // Descriptor as the packet rules define it
    function automatic desc_t expected_desc();
        desc_t d;
        d = '0;
        foreach (pkt_q[i]) begin
            d.beats = d.beats + 1;
            for (int k = 0; k < DATA_BYTES; k++) begin
                d.bytes = d.bytes + pkt_q[i].keep[k];
            end
            d.err = d.err | pkt_q[i].user;
        end
        d.oversize = (d.beats > max_beats_cfg);
        return d;
    endfunction

    task automatic send_packet();
        int waited;
        foreach (pkt_q[i]) begin
            @(negedge clk);
            s_beat  = pkt_q[i];
            s_valid = 1'b1;
            waited  = 0;
            while (!s_ready) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) timeout_fail("s_ready");
            end
        end
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic recv_beat();
        beat_t exp;
        int    waited;
        logic  got;
        exp    = exp_q.pop_front();
        waited = 0;
        got    = 1'b0;
        while (!got) begin
            @(negedge clk);
            m_ready = !(stall_en && ($random(seed) & 1));
            if (m_ready && m_valid) begin
                check("m_beat.data", m_beat.data, exp.data);
                check("m_beat.keep", m_beat.keep, exp.keep);
                check("m_beat.last", m_beat.last, exp.last);
                check("m_beat.user", m_beat.user, exp.user);
                got = 1'b1;
            end else begin
                waited++;
                if (waited > TIMEOUT) timeout_fail("a data beat");
            end
        end
    endtask

    task automatic recv_desc(input desc_t exp);
        int waited;
        waited = 0;
        @(negedge clk);
        m_desc_ready = 1'b1;
        while (!m_desc_valid) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_fail("a descriptor");
        end
        check("m_desc.beats", m_desc.beats, exp.beats);
        check("m_desc.bytes", m_desc.bytes, exp.bytes);
        check("m_desc.err", m_desc.err, exp.err);
        check("m_desc.oversize", m_desc.oversize, exp.oversize);
        @(negedge clk);
        m_desc_ready = 1'b0;
    endtask

    // Sender and sink run side by side, then the descriptor is taken
    task automatic run_packet(input logic stall);
        desc_t exp_d;
        int    n;
        exp_d = expected_desc();
        n     = pkt_q.size();
        foreach (pkt_q[i]) exp_q.push_back(pkt_q[i]);
        stall_en = stall;
        fork
            send_packet();
            begin
                for (int i = 0; i < n; i++) recv_beat();
                @(negedge clk);
                m_ready = 1'b0;
            end
        join
        recv_desc(exp_d);
        pkts_sent++;
        if (exp_d.oversize) oversize_sent++;
    endtask

    // Offer a beat and expect the link to refuse it with idle outputs
    task automatic idle_window(input int cycles);
        @(negedge clk);
        s_beat  = '{data: 32'hdead_0000, keep: 4'hf, last: 1'b1, user: 1'b0};
        s_valid = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check("s_ready", s_ready, 1'b0);
            check("m_valid", m_valid, 1'b0);
            check("m_desc_valid", m_desc_valid, 1'b0);
            check("csr_rsp.valid", csr_rsp.valid, 1'b0);
        end
        s_valid = 1'b0;
    endtask

    task automatic test_after_reset();
        logic [15:0] v;
        idle_window(20);
        csr_read(ADDR_CTRL, v);
        check("ctrl", v, 16'd0);
        csr_read(ADDR_MAX_BEATS, v);
        check("max_beats", v, 16'd16);
        csr_read(ADDR_PKT_COUNT, v);
        check("pkt_count", v, 16'd0);
        csr_read(ADDR_OVERSIZE_COUNT, v);
        check("oversize_count", v, 16'd0);
    endtask

    task automatic test_single_packet();
        csr_write(ADDR_CTRL, 16'd1);
        build_packet(3, 1);
        run_packet(1'b0);
    endtask

    task automatic test_back_pressure();
        // Limit raised so the long packet is not oversize
        csr_write(ADDR_MAX_BEATS, 16'd64);
        max_beats_cfg = 64;
        build_packet(40, 2);
        run_packet(1'b1);
    endtask

    task automatic test_measurement();
        build_packet(4, 3);
        mark_beat(1, 4'hf, 1'b1);
        mark_beat(3, 4'b0101, 1'b0);
        run_packet(1'b1);
    endtask

    task automatic test_oversize();
        logic [15:0] v;
        csr_write(ADDR_MAX_BEATS, 16'd3);
        max_beats_cfg = 3;
        build_packet(5, 4);
        run_packet(1'b0);
        csr_read(ADDR_OVERSIZE_COUNT, v);
        check("oversize_count", v, oversize_sent);
    endtask

    task automatic test_disable();
        logic [15:0] v;
        csr_write(ADDR_CTRL, 16'd0);
        csr_read(ADDR_CTRL, v);
        check("ctrl", v, 16'd0);
        idle_window(20);
        csr_write(ADDR_CTRL, 16'd1);
        build_packet(2, 5);
        run_packet(1'b0);
        csr_read(ADDR_PKT_COUNT, v);
        check("pkt_count", v, pkts_sent);
    endtask

    initial begin
        rst           = 1'b1;
        s_beat        = '0;
        s_valid       = 1'b0;
        m_ready       = 1'b0;
        m_desc_ready  = 1'b0;
        csr_req       = '0;
        stall_en      = 1'b0;
        max_beats_cfg = 16;
        pkts_sent     = 0;
        oversize_sent = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_after_reset();
        test_single_packet();
        test_back_pressure();
        test_measurement();
        test_oversize();
        test_disable();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verilog/stream_link_top.sv ====
// --------------------------------------
// Stream link top level
// Monitor, data and descriptor pipelines
// and the register block
// --------------------------------------
module stream_link_top #(
    parameter int DATA_LENGTH = 4,
    parameter int DESC_LENGTH = 2
) (
    input  logic              clk,
    input  logic              rst,

    input  stream_pkg::beat_t s_beat,
    input  logic              s_valid,
    output logic              s_ready,

    output stream_pkg::beat_t m_beat,
    output logic              m_valid,
    input  logic              m_ready,

    output stream_pkg::desc_t m_desc,
    output logic              m_desc_valid,
    input  logic              m_desc_ready,

    input  csr_pkg::csr_req_t csr_req,
    output csr_pkg::csr_rsp_t csr_rsp
);

    import stream_pkg::*;

    beat_t                mon_beat;
    logic                 mon_valid;
    logic                 mon_ready;
    desc_t                mon_desc;
    logic                 mon_desc_valid;
    logic                 mon_desc_ready;
    logic                 enable;
    logic [CNT_WIDTH-1:0] max_beats;
    logic                 pkt_done;
    logic                 pkt_oversize;

    pkt_monitor monitor0 (
        .clk          (clk),
        .rst          (rst),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .o_beat       (mon_beat),
        .o_valid      (mon_valid),
        .o_ready      (mon_ready),
        .desc         (mon_desc),
        .desc_valid   (mon_desc_valid),
        .desc_ready   (mon_desc_ready),
        .enable       (enable),
        .max_beats    (max_beats),
        .pkt_done     (pkt_done),
        .pkt_oversize (pkt_oversize)
    );

    pipeline_fifo #(
        .LENGTH    (DATA_LENGTH),
        .payload_t (beat_t)
    ) data_fifo0 (
        .clk     (clk),
        .rst     (rst),
        .s_data  (mon_beat),
        .s_valid (mon_valid),
        .s_ready (mon_ready),
        .m_data  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    pipeline_fifo #(
        .LENGTH    (DESC_LENGTH),
        .payload_t (desc_t)
    ) desc_fifo0 (
        .clk     (clk),
        .rst     (rst),
        .s_data  (mon_desc),
        .s_valid (mon_desc_valid),
        .s_ready (mon_desc_ready),
        .m_data  (m_desc),
        .m_valid (m_desc_valid),
        .m_ready (m_desc_ready)
    );

    link_csr csr0 (
        .clk          (clk),
        .rst          (rst),
        .req          (csr_req),
        .rsp          (csr_rsp),
        .enable       (enable),
        .max_beats    (max_beats),
        .pkt_done     (pkt_done),
        .pkt_oversize (pkt_oversize)
    );

endmodule

// ==== verilog/link_csr.sv ====
// --------------------------------------
// Link control and status registers
// Enable, length limit and event counters
// --------------------------------------
module link_csr (
    input  logic                                clk,
    input  logic                                rst,

    input  csr_pkg::csr_req_t                   req,
    output csr_pkg::csr_rsp_t                   rsp,

    output logic                                enable,
    output logic [csr_pkg::CSR_DATA_WIDTH-1:0]  max_beats,
    input  logic                                pkt_done,
    input  logic                                pkt_oversize
);

    import csr_pkg::*;

    logic [CSR_DATA_WIDTH-1:0] pkt_count;
    logic [CSR_DATA_WIDTH-1:0] oversize_count;
    logic [CSR_DATA_WIDTH-1:0] rd_value;
    logic [CSR_DATA_WIDTH-1:0] rdata_reg;
    logic                      rsp_valid_reg;

    // Read mux
    always_comb begin
        case (req.addr)
            ADDR_CTRL:           rd_value = {{(CSR_DATA_WIDTH - 1){1'b0}}, enable};
            ADDR_MAX_BEATS:      rd_value = max_beats;
            ADDR_PKT_COUNT:      rd_value = pkt_count;
            ADDR_OVERSIZE_COUNT: rd_value = oversize_count;
            default:             rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable         <= 1'b0;
            max_beats      <= MAX_BEATS_RESET;
            pkt_count      <= '0;
            oversize_count <= '0;
            rsp_valid_reg  <= 1'b0;
        end else begin
            rsp_valid_reg <= req.rd;
            // Counter addresses are read only
            if (req.wr && req.addr == ADDR_CTRL) begin
                enable <= req.wdata[0];
            end
            if (req.wr && req.addr == ADDR_MAX_BEATS) begin
                max_beats <= req.wdata;
            end
            if (pkt_done) begin
                pkt_count <= pkt_count + 1'b1;
            end
            if (pkt_oversize) begin
                oversize_count <= oversize_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.rd) begin
            rdata_reg <= rd_value;
        end
    end

    assign rsp.valid = rsp_valid_reg;
    assign rsp.rdata = rdata_reg;

endmodule

// ==== verilog/pkt_monitor.sv ====
// --------------------------------------
// Packet monitor
// Gates packets and emits one descriptor
// per packet with its measurements
// --------------------------------------
module pkt_monitor (
    input  logic                             clk,
    input  logic                             rst,

    input  stream_pkg::beat_t                s_beat,
    input  logic                             s_valid,
    output logic                             s_ready,

    output stream_pkg::beat_t                o_beat,
    output logic                             o_valid,
    input  logic                             o_ready,

    output stream_pkg::desc_t                desc,
    output logic                             desc_valid,
    input  logic                             desc_ready,

    input  logic                             enable,
    input  logic [stream_pkg::CNT_WIDTH-1:0] max_beats,
    output logic                             pkt_done,
    output logic                             pkt_oversize
);

    import stream_pkg::*;

    logic                 in_pkt;
    logic                 gate;
    logic                 accept;
    logic [CNT_WIDTH-1:0] beat_cnt;
    logic [CNT_WIDTH-1:0] byte_cnt;
    logic                 err_acc;
    logic [CNT_WIDTH-1:0] keep_bytes;
    logic [CNT_WIDTH-1:0] beats_next;
    logic [CNT_WIDTH-1:0] bytes_next;
    logic                 err_next;
    logic                 oversize_next;
    desc_t                desc_reg;
    logic                 desc_valid_reg;

    // A new packet starts only when enabled and the descriptor slot is empty
    assign gate    = in_pkt || (enable && !desc_valid_reg);
    assign o_beat  = s_beat;
    assign o_valid = s_valid && gate;
    assign s_ready = o_ready && gate;
    assign accept  = s_valid && s_ready;

    // Bytes in this beat
    always_comb begin
        keep_bytes = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep_bytes = keep_bytes + CNT_WIDTH'(s_beat.keep[i]);
        end
    end

    assign beats_next    = beat_cnt + 1'b1;
    assign bytes_next    = byte_cnt + keep_bytes;
    assign err_next      = err_acc || s_beat.user;
    assign oversize_next = (beats_next > max_beats);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt         <= 1'b0;
            beat_cnt       <= '0;
            byte_cnt       <= '0;
            err_acc        <= 1'b0;
            desc_valid_reg <= 1'b0;
            pkt_done       <= 1'b0;
            pkt_oversize   <= 1'b0;
        end else begin
            pkt_done     <= 1'b0;
            pkt_oversize <= 1'b0;
            if (desc_valid_reg && desc_ready) begin
                desc_valid_reg <= 1'b0;
            end
            if (accept) begin
                if (s_beat.last) begin
                    in_pkt         <= 1'b0;
                    beat_cnt       <= '0;
                    byte_cnt       <= '0;
                    err_acc        <= 1'b0;
                    desc_valid_reg <= 1'b1;
                    pkt_done       <= 1'b1;
                    pkt_oversize   <= oversize_next;
                end else begin
                    in_pkt   <= 1'b1;
                    beat_cnt <= beats_next;
                    byte_cnt <= bytes_next;
                    err_acc  <= err_next;
                end
            end
        end
    end

    // Descriptor payload, loaded on the last beat
    always_ff @(posedge clk) begin
        if (accept && s_beat.last) begin
            desc_reg.beats    <= beats_next;
            desc_reg.bytes    <= bytes_next;
            desc_reg.err      <= err_next;
            desc_reg.oversize <= oversize_next;
        end
    end

    assign desc       = desc_reg;
    assign desc_valid = desc_valid_reg;

endmodule

// ==== verilog/pipeline_fifo.sv ====
// --------------------------------------
// Pipeline FIFO
// Register pipeline with delayed ready and
// an output FIFO for the beats in flight
// --------------------------------------
module pipeline_fifo #(
    parameter int  LENGTH    = 2,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,

    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    // Depth above four times the length, so everything in flight fits
    localparam int FIFO_AW    = (LENGTH < 2) ? 3 : $clog2(LENGTH * 4 + 1);
    localparam int FIFO_DEPTH = 2 ** FIFO_AW;

    generate
        if (LENGTH > 0) begin : g_pipe
            payload_t         data_pipe [LENGTH];
            logic             valid_pipe [LENGTH];
            logic             ready_pipe [LENGTH];

            payload_t         fifo_mem [FIFO_DEPTH];
            logic [FIFO_AW:0] wr_ptr;
            logic [FIFO_AW:0] rd_ptr;
            logic [FIFO_AW:0] fill;
            logic             fifo_full;
            logic             fifo_empty;
            logic             fifo_wr;
            logic             fifo_rd;
            logic             half_full;

            payload_t         out_data;
            logic             out_valid;

            assign s_ready = ready_pipe[0];

            // Fill level reaches the top bit only when completely full
            assign fill       = wr_ptr - rd_ptr;
            assign fifo_full  = fill[FIFO_AW];
            assign fifo_empty = (fill == '0);
            assign fifo_wr    = valid_pipe[LENGTH-1] && !fifo_full;
            assign fifo_rd    = !fifo_empty && (!out_valid || m_ready);

            // Payload shifts forward every cycle
            always_ff @(posedge clk) begin
                data_pipe[0] <= s_data;
                for (int i = 1; i < LENGTH; i++) begin
                    data_pipe[i] <= data_pipe[i-1];
                end
            end

            // Valid moves forward, ready moves backward
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < LENGTH; i++) begin
                        valid_pipe[i] <= 1'b0;
                        ready_pipe[i] <= 1'b0;
                    end
                end else begin
                    valid_pipe[0]        <= s_valid && ready_pipe[0];
                    ready_pipe[LENGTH-1] <= !half_full;
                    for (int i = 1; i < LENGTH; i++) begin
                        valid_pipe[i]   <= valid_pipe[i-1];
                        ready_pipe[i-1] <= ready_pipe[i];
                    end
                end
            end

            // Output FIFO pointers and output register state
            always_ff @(posedge clk) begin
                if (rst) begin
                    wr_ptr    <= '0;
                    rd_ptr    <= '0;
                    half_full <= 1'b0;
                    out_valid <= 1'b0;
                end else begin
                    half_full <= (fill >= FIFO_DEPTH / 2);
                    if (fifo_wr) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (fifo_rd) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    out_valid <= fifo_rd || (out_valid && !m_ready);
                end
            end

            // Distributed memory, read asynchronously into the output register
            always_ff @(posedge clk) begin
                if (fifo_wr) begin
                    fifo_mem[wr_ptr[FIFO_AW-1:0]] <= data_pipe[LENGTH-1];
                end
                if (fifo_rd) begin
                    out_data <= fifo_mem[rd_ptr[FIFO_AW-1:0]];
                end
            end

            assign m_data  = out_data;
            assign m_valid = out_valid;
        end else begin : g_bypass
            // Zero length is a plain wire
            assign m_data  = s_data;
            assign m_valid = s_valid;
            assign s_ready = m_ready;
        end
    endgenerate

endmodule

// ==== verilog/csr_pkg.sv ====
// --------------------------------------
// Control bus definitions
// Register map and request/response format
// --------------------------------------
package csr_pkg;

    localparam int CSR_ADDR_WIDTH = 2;
    localparam int CSR_DATA_WIDTH = 16;

    localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_CTRL           = 2'd0;
    localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_MAX_BEATS      = 2'd1;
    localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_PKT_COUNT      = 2'd2;
    localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_OVERSIZE_COUNT = 2'd3;

    localparam logic [CSR_DATA_WIDTH-1:0] MAX_BEATS_RESET = 16'd16;

    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [CSR_ADDR_WIDTH-1:0] addr;
        logic [CSR_DATA_WIDTH-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic                      valid;
        logic [CSR_DATA_WIDTH-1:0] rdata;
    } csr_rsp_t;

endpackage

// ==== verilog/stream_pkg.sv ====
// --------------------------------------
// Stream formats
// Beat and packet descriptor layouts
// --------------------------------------
package stream_pkg;

    // Bytes carried per beat
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = DATA_BYTES * 8;

    // Width of the beat and byte counts in a descriptor
    localparam int CNT_WIDTH = 16;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        // Error marker from the source
        logic                  user;
    } beat_t;

    typedef struct packed {
        logic [CNT_WIDTH-1:0] beats;
        logic [CNT_WIDTH-1:0] bytes;
        logic                 err;
        logic                 oversize;
    } desc_t;

endpackage
